// ==== design/mc_pkg.sv ====
// shared widths, timing constants and enums for the dual-core bus subsystem
// referenced by scoped name from every design and test file
`default_nettype none

package mc_pkg;

    localparam int addr_w = 8;
    localparam int data_w = 32;

    typedef logic [data_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    localparam int dram_words   = 2 ** addr_w;
    localparam int dram_lat     = 3;  // cycles busy per access
    localparam int slice_cycles = 4;  // run slice after a grant switch

    localparam int lat_w   = $clog2(dram_lat + 1);
    localparam int slice_w = $clog2(slice_cycles + 1);

    localparam logic [lat_w-1:0]   lat_init   = lat_w'(dram_lat);
    localparam logic [lat_w-1:0]   lat_one    = lat_w'(1);
    localparam logic [slice_w-1:0] slice_last = slice_w'(slice_cycles - 1);
    localparam addr_t              last_word  = addr_t'(dram_words - 1);

    // instruction word fields
    localparam int op_msb  = 31;
    localparam int op_lsb  = 24;
    localparam int imm_msb = 23;
    localparam int imm_lsb = 0;
    localparam int adr_msb = 7;
    localparam int adr_lsb = 0;

    typedef enum logic [2:0] {s_if, s_id, s_ex, s_ma, s_wb} core_state_e;

    typedef enum logic [7:0] {
        op_nop  = 8'h00,
        op_ldi  = 8'h01,
        op_ld   = 8'h02,
        op_add  = 8'h03,
        op_st   = 8'h04,
        op_halt = 8'hff
    } opcode_e;

    typedef enum logic [1:0] {arb_wait, arb_switch, arb_settle, arb_run} arb_state_e;

endpackage

`default_nettype wire

// ==== design/core_bus_if.sv ====
// one core's request and response path to the shared memory
// the core drives the request side, the arbiter returns data and busy
`timescale 1ns/1ps
`default_nettype none

interface core_bus_if;

    mc_pkg::core_state_e cpustate;  // seen by the arbiter for switching
    mc_pkg::addr_t       paddr;
    mc_pkg::word_t       wdata;
    logic                we;        // one-cycle write pulse
    logic                le;        // one-cycle load pulse
    mc_pkg::word_t       rdata;
    logic                busy;      // level, high while not usable

    modport core (
        output cpustate,
        output paddr,
        output wdata,
        output we,
        output le,
        input  rdata,
        input  busy
    );

    modport arbiter (
        input  cpustate,
        input  paddr,
        input  wdata,
        input  we,
        input  le,
        output rdata,
        output busy
    );

endinterface

`default_nettype wire

// ==== design/mini_core.sv ====
// accumulator core stepping IF, ID, EX, MA, WB with one bus access per instruction
// instructions come from the ir port, data goes through the shared bus
`timescale 1ns/1ps
`default_nettype none

module mini_core (
    input  wire logic           CLK,
    input  wire logic           RST_X,
    core_bus_if.core            bus,
    output mc_pkg::addr_t       pc,
    input  wire mc_pkg::word_t  ir,
    output logic                retire,
    output mc_pkg::word_t       acc,
    output logic                halted
);

    mc_pkg::core_state_e state;
    mc_pkg::word_t       ir_q;
    mc_pkg::opcode_e     op;
    logic                is_mem;
    logic                issued;  // pulse already sent for this access
    logic                go;

    assign op     = mc_pkg::opcode_e'(ir_q[mc_pkg::op_msb:mc_pkg::op_lsb]);
    assign is_mem = (op == mc_pkg::op_ld) || (op == mc_pkg::op_add) || (op == mc_pkg::op_st);
    assign go     = (state == mc_pkg::s_ma) && !issued && !bus.busy;

    assign bus.cpustate = state;
    assign bus.paddr    = ir_q[mc_pkg::adr_msb:mc_pkg::adr_lsb];
    assign bus.wdata    = acc;
    assign bus.le       = go && (op != mc_pkg::op_st);
    assign bus.we       = go && (op == mc_pkg::op_st);

    // a parked halt sits in s_wb without retiring
    assign retire = (state == mc_pkg::s_wb) && (op != mc_pkg::op_halt);

    always_ff @(posedge CLK) begin
        if (state == mc_pkg::s_id) begin
            ir_q <= ir;  // ir valid one cycle after pc moved
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state  <= mc_pkg::s_if;
            pc     <= '0;
            acc    <= '0;
            issued <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (state)
                mc_pkg::s_if: begin
                    state <= mc_pkg::s_id;
                end
                mc_pkg::s_id: begin
                    state <= mc_pkg::s_ex;
                end
                mc_pkg::s_ex: begin
                    issued <= 1'b0;
                    if (is_mem) begin
                        state <= mc_pkg::s_ma;
                    end else begin
                        state <= mc_pkg::s_wb;
                    end
                    if (op == mc_pkg::op_ldi) begin
                        acc <= mc_pkg::word_t'(ir_q[mc_pkg::imm_msb:mc_pkg::imm_lsb]);
                    end
                end
                mc_pkg::s_ma: begin
                    if (go) begin
                        issued <= 1'b1;
                    end else if (issued && !bus.busy) begin  // data valid as busy drops
                        if (op == mc_pkg::op_ld) begin
                            acc <= bus.rdata;
                        end else if (op == mc_pkg::op_add) begin
                            acc <= acc + bus.rdata;
                        end
                        state <= mc_pkg::s_wb;
                    end
                end
                mc_pkg::s_wb: begin
                    if (op == mc_pkg::op_halt) begin
                        halted <= 1'b1;  // parked, never reaches s_id again
                    end else begin
                        pc    <= pc + 1'b1;
                        state <= mc_pkg::s_if;
                    end
                end
                default: begin
                    state <= mc_pkg::s_if;
                end
            endcase
        end
    end

    a_known_opcode: assert property (@(posedge CLK) disable iff (!RST_X)
        (state == mc_pkg::s_id) |-> (ir[mc_pkg::op_msb:mc_pkg::op_lsb] inside {
            mc_pkg::op_nop, mc_pkg::op_ldi, mc_pkg::op_ld,
            mc_pkg::op_add, mc_pkg::op_st, mc_pkg::op_halt}));

    // capture waits for busy, so busy has to rise right after the pulse
    a_busy_after_pulse: assert property (@(posedge CLK) disable iff (!RST_X)
        (bus.le || bus.we) |=> bus.busy);

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
// round-robin owner of the shared memory between two cores
// switches at the owner's decode state, then gives the new owner a fixed slice
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire logic           CLK,
    input  wire logic           RST_X,
    core_bus_if.arbiter         c0,
    core_bus_if.arbiter         c1,
    output logic                grant,
    input  wire logic           halted0,
    input  wire logic           halted1,
    output mc_pkg::addr_t       m_paddr,
    output mc_pkg::word_t       m_wdata,
    output logic                m_we,
    output logic                m_le,
    input  wire mc_pkg::word_t  m_rdata,
    input  wire logic           m_busy
);

    mc_pkg::arb_state_e         state;
    logic [mc_pkg::slice_w-1:0] cnt;
    mc_pkg::core_state_e        own_state;
    logic                       own_halted;
    logic                       other_halted;
    logic                       may_switch;
    logic                       hold;
    logic                       owner_busy;

    assign own_state    = grant ? c1.cpustate : c0.cpustate;
    assign own_halted   = grant ? halted1 : halted0;
    assign other_halted = grant ? halted0 : halted1;

    // never hand the bus to a core that has halted
    assign may_switch = ((own_state == mc_pkg::s_id) || own_halted) && !other_halted;

    assign hold       = (state == mc_pkg::arb_switch) || (state == mc_pkg::arb_settle);
    assign owner_busy = hold || m_busy;

    // request side follows the owner
    assign m_paddr = grant ? c1.paddr : c0.paddr;
    assign m_wdata = grant ? c1.wdata : c0.wdata;
    assign m_we    = grant ? c1.we    : c0.we;
    assign m_le    = grant ? c1.le    : c0.le;

    // the other core sees a busy, silent bus
    assign c0.rdata = grant ? '0 : m_rdata;
    assign c0.busy  = grant ? 1'b1 : owner_busy;
    assign c1.rdata = grant ? m_rdata : '0;
    assign c1.busy  = grant ? owner_busy : 1'b1;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state <= mc_pkg::arb_wait;
            grant <= 1'b0;
            cnt   <= '0;
        end else begin
            case (state)
                mc_pkg::arb_wait: begin
                    if (may_switch) begin
                        state <= mc_pkg::arb_switch;
                    end
                end
                mc_pkg::arb_switch: begin
                    grant <= ~grant;  // old owner still held busy
                    state <= mc_pkg::arb_settle;
                end
                mc_pkg::arb_settle: begin
                    cnt   <= '0;
                    state <= mc_pkg::arb_run;
                end
                mc_pkg::arb_run: begin
                    if (cnt == mc_pkg::slice_last) begin
                        state <= mc_pkg::arb_wait;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= mc_pkg::arb_wait;
                end
            endcase
        end
    end

    a_no_pulse_in_switch: assert property (@(posedge CLK) disable iff (!RST_X)
        hold |-> !(m_we || m_le));

endmodule

`default_nettype wire

// ==== design/shared_dram.sv ====
// word-addressed data memory with fixed access latency and a busy level
// zeroed by a walk after reset, busy stays high until the walk ends
`timescale 1ns/1ps
`default_nettype none

module shared_dram (
    input  wire logic           CLK,
    input  wire logic           RST_X,
    input  wire mc_pkg::addr_t  paddr,
    input  wire mc_pkg::word_t  wdata,
    input  wire logic           we,
    input  wire logic           le,
    output mc_pkg::word_t       rdata,
    output logic                busy
);

    mc_pkg::word_t            mem [mc_pkg::dram_words];
    logic                     clr_active;
    mc_pkg::addr_t            clr_idx;
    mc_pkg::addr_t            rd_addr;
    logic [mc_pkg::lat_w-1:0] lat_cnt;
    logic                     rd_pend;  // current access is a load

    assign busy = clr_active || (lat_cnt != '0);

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            clr_active <= 1'b1;
            clr_idx    <= '0;
            lat_cnt    <= '0;
            rd_pend    <= 1'b0;
        end else begin
            if (clr_active) begin
                clr_idx <= clr_idx + 1'b1;
                if (clr_idx == mc_pkg::last_word) begin
                    clr_active <= 1'b0;
                end
            end
            if (le || we) begin
                lat_cnt <= mc_pkg::lat_init;  // busy from next cycle
                rd_pend <= le;
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (clr_active) begin
            mem[clr_idx] <= '0;
        end else if (we) begin
            mem[paddr] <= wdata;  // write lands at the pulse
        end
        if (le) begin
            rd_addr <= paddr;
        end
        if (rd_pend && (lat_cnt == mc_pkg::lat_one)) begin
            rdata <= mem[rd_addr];  // shows as busy falls
        end
    end

    a_no_pulse_while_busy: assert property (@(posedge CLK) disable iff (!RST_X)
        busy |-> !(le || we));

endmodule

`default_nettype wire

// ==== design/dual_core_top.sv ====
// two accumulator cores sharing one data memory through the bus arbiter
// instruction fetch and status are plain ports for the testbench
`timescale 1ns/1ps
`default_nettype none

module dual_core_top (
    input  wire logic           CLK,
    input  wire logic           RST_X,
    output mc_pkg::addr_t       pc0,
    output mc_pkg::addr_t       pc1,
    input  wire mc_pkg::word_t  ir0,
    input  wire mc_pkg::word_t  ir1,
    output logic                retire0,
    output logic                retire1,
    output mc_pkg::word_t       acc0,
    output mc_pkg::word_t       acc1,
    output logic                halted0,
    output logic                halted1,
    output logic                mem_we,
    output mc_pkg::addr_t       mem_addr,
    output mc_pkg::word_t       mem_wdata,
    output logic                grant
);

    mc_pkg::addr_t m_paddr;
    mc_pkg::word_t m_wdata;
    mc_pkg::word_t m_rdata;
    logic          m_we;
    logic          m_le;
    logic          m_busy;

    core_bus_if c0_bus ();
    core_bus_if c1_bus ();

    mini_core u_core0 (
        .CLK    (CLK),
        .RST_X  (RST_X),
        .bus    (c0_bus.core),
        .pc     (pc0),
        .ir     (ir0),
        .retire (retire0),
        .acc    (acc0),
        .halted (halted0)
    );

    mini_core u_core1 (
        .CLK    (CLK),
        .RST_X  (RST_X),
        .bus    (c1_bus.core),
        .pc     (pc1),
        .ir     (ir1),
        .retire (retire1),
        .acc    (acc1),
        .halted (halted1)
    );

    bus_arbiter u_arb (
        .CLK     (CLK),
        .RST_X   (RST_X),
        .c0      (c0_bus.arbiter),
        .c1      (c1_bus.arbiter),
        .grant   (grant),
        .halted0 (halted0),
        .halted1 (halted1),
        .m_paddr (m_paddr),
        .m_wdata (m_wdata),
        .m_we    (m_we),
        .m_le    (m_le),
        .m_rdata (m_rdata),
        .m_busy  (m_busy)
    );

    shared_dram u_dram (
        .CLK   (CLK),
        .RST_X (RST_X),
        .paddr (m_paddr),
        .wdata (m_wdata),
        .we    (m_we),
        .le    (m_le),
        .rdata (m_rdata),
        .busy  (m_busy)
    );

    // store strobe as the memory sees it
    assign mem_we    = m_we;
    assign mem_addr  = m_paddr;
    assign mem_wdata = m_wdata;

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// clock and reset source for the dual-core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic CLK,
    output logic RST_X
);

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;  // 8 ns period
        end
    end

    initial begin
        RST_X <= 1'b0;
        repeat (4) @(posedge CLK);
        RST_X <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_checks.svh ====
// compare and abort tasks for the dual-core testbench
// included inside the testbench top module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic abort_run(input string why);
    $display("Test failures found");
    $fatal(1, "%s", why);
endtask

task automatic check_word(input string name, input mc_pkg::word_t got,
                          input mc_pkg::word_t exp);
    if (got !== exp) begin
        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        abort_run($sformatf("%s does not match", name));
    end
endtask

task automatic check_addr(input string name, input mc_pkg::addr_t got,
                          input mc_pkg::addr_t exp);
    if (got !== exp) begin
        $display("FAIL %s got 0x%02h expected 0x%02h", name, got, exp);
        abort_run($sformatf("%s does not match", name));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        abort_run($sformatf("%s does not match", name));
    end
endtask

`endif

// ==== test/tb_dual_core.sv ====
// testbench top for the dual-core subsystem, serves both instruction ports
// checks retirements, stores and bus sharing against test/core_vectors.txt
`timescale 1ns/1ps
`default_nettype none

module tb_dual_core;

    localparam int vec_words     = 256;
    localparam int row_w         = 5;   // core, flags, instr, acc, store addr
    localparam int max_ret       = 64;
    localparam int max_st        = 32;
    localparam int cyc_per_instr = 400;
    localparam int clear_cycles  = 256;

    logic          CLK;
    logic          RST_X;
    mc_pkg::addr_t pc0;
    mc_pkg::addr_t pc1;
    mc_pkg::word_t ir0 = '0;
    mc_pkg::word_t ir1 = '0;
    logic          retire0;
    logic          retire1;
    mc_pkg::word_t acc0;
    mc_pkg::word_t acc1;
    logic          halted0;
    logic          halted1;
    logic          mem_we;
    mc_pkg::addr_t mem_addr;
    mc_pkg::word_t mem_wdata;
    logic          grant;

    logic [31:0]   vec [vec_words];
    mc_pkg::word_t prog [2][256];
    mc_pkg::word_t exp_acc [2][max_ret];
    mc_pkg::addr_t exp_st_addr [2][max_st];
    mc_pkg::word_t exp_st_data [2][max_st];
    int            n_ret [2] = '{0, 0};
    int            n_st [2] = '{0, 0};
    int            ret_idx [2] = '{0, 0};
    int            st_idx [2] = '{0, 0};
    logic          halt_seen [2] = '{1'b0, 1'b0};
    int            n_instr = 0;
    logic          loaded = 1'b0;
    logic          grant_q = 1'b0;
    int            grant_changes = 0;
    int            since_grant = 0;
    logic          seen_grant1 = 1'b0;

    `include "tb_checks.svh"

    tb_clock_gen u_clock_gen (.CLK(CLK), .RST_X(RST_X));

    dual_core_top u_dual_core_top (
        .CLK(CLK), .RST_X(RST_X), .pc0(pc0), .pc1(pc1), .ir0(ir0), .ir1(ir1),
        .retire0(retire0), .retire1(retire1), .acc0(acc0), .acc1(acc1),
        .halted0(halted0), .halted1(halted1), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .grant(grant)
    );

    // flag bits 1 random imm, 2 acc relative to that random, 4 store, 8 halt
    task automatic load_vectors();
        int            base;
        int            c;
        int            pcn [2];
        logic [31:0]   flags;
        mc_pkg::word_t instr;
        mc_pkg::word_t val;
        mc_pkg::word_t rnd [2];
        $readmemh("test/core_vectors.txt", vec);
        pcn  = '{0, 0};
        rnd  = '{'0, '0};
        base = 0;
        while ((base + row_w <= vec_words) && (vec[base] != 32'hffff_ffff)) begin
            c     = vec[base][0] ? 1 : 0;
            flags = vec[base+1];
            instr = vec[base+2];
            val   = vec[base+3];
            if (flags[0]) begin
                rnd[c] = $urandom() & 32'h00ff_ffff;  // 24-bit immediate
                instr  = instr | rnd[c];
            end
            if (flags[1]) begin
                val = val + rnd[c];
            end
            prog[c][pcn[c]] = instr;
            pcn[c]          = pcn[c] + 1;
            n_instr         = n_instr + 1;
            if (!flags[3]) begin
                exp_acc[c][n_ret[c]] = val;
                n_ret[c]             = n_ret[c] + 1;
            end
            if (flags[2]) begin
                exp_st_addr[c][n_st[c]] = mc_pkg::addr_t'(vec[base+4]);
                exp_st_data[c][n_st[c]] = val;  // st keeps acc unchanged
                n_st[c]                 = n_st[c] + 1;
            end
            base = base + row_w;
        end
    endtask

    task automatic track_grant();
        if ((grant != grant_q) && (grant_changes > 0) &&
                (since_grant < mc_pkg::slice_cycles + 2)) begin
            abort_run("grant changed again before the run slice ended");
        end else if (grant != grant_q) begin
            grant_changes = grant_changes + 1;
            since_grant   = 0;
            grant_q       = grant;
            if (grant) begin
                seen_grant1 = 1'b1;
            end
        end else begin
            since_grant = since_grant + 1;
        end
    endtask

    task automatic check_store();
        int c;
        c = grant ? 1 : 0;
        if (st_idx[c] >= n_st[c]) begin
            abort_run($sformatf("core %0d wrote memory more often than expected", c));
        end else begin
            check_addr("mem_addr", mem_addr, exp_st_addr[c][st_idx[c]]);
            check_word("mem_wdata", mem_wdata, exp_st_data[c][st_idx[c]]);
            st_idx[c] = st_idx[c] + 1;
        end
    endtask

    task automatic check_retirement(input int c, input mc_pkg::word_t acc, input logic halted);
        if (halted) begin
            abort_run($sformatf("core %0d retired after it had halted", c));
        end else if (ret_idx[c] >= n_ret[c]) begin
            abort_run($sformatf("core %0d retired more often than expected", c));
        end else begin
            check_word(c ? "acc1" : "acc0", acc, exp_acc[c][ret_idx[c]]);
            ret_idx[c] = ret_idx[c] + 1;
        end
    endtask

    task automatic check_halt(input int c);
        halt_seen[c] = 1'b1;
        if (ret_idx[c] != n_ret[c]) begin
            abort_run($sformatf("core %0d halted before its last retirement", c));
        end else if (!seen_grant1) begin
            abort_run("a core halted before the bus was ever granted to core 1");
        end
    endtask

    always @(posedge CLK) begin
        ir0 <= prog[0][pc0];
        ir1 <= prog[1][pc1];
    end

    // outputs settle after the rising edge
    always @(negedge CLK) begin
        if (RST_X && loaded) begin
            track_grant();
            if (mem_we) check_store();
            if (retire0) check_retirement(0, acc0, halted0);
            if (retire1) check_retirement(1, acc1, halted1);
            if (halted0 && !halt_seen[0]) check_halt(0);
            if (halted1 && !halt_seen[1]) check_halt(1);
        end
    end

    initial begin
        void'($urandom(8));
        load_vectors();
        loaded = 1'b1;
        @(posedge RST_X);
        @(negedge CLK);
        check_bit("grant", grant, 1'b0);
        check_bit("retire0", retire0, 1'b0);
        check_bit("retire1", retire1, 1'b0);
        check_bit("mem_we", mem_we, 1'b0);
        check_bit("halted0", halted0, 1'b0);
        check_bit("halted1", halted1, 1'b0);
        check_addr("pc0", pc0, '0);
        check_addr("pc1", pc1, '0);
        wait (halted0 && halted1);
        repeat (mc_pkg::slice_cycles + 4) @(negedge CLK);  // catch stray pulses
        if ((ret_idx[0] != n_ret[0]) || (ret_idx[1] != n_ret[1]) ||
                (st_idx[0] != n_st[0]) || (st_idx[1] != n_st[1])) begin
            abort_run("run ended with expected retirements or stores missing");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    initial begin
        wait (loaded);
        repeat (n_instr * cyc_per_instr + clear_cycles) @(posedge CLK);
        abort_run("timeout because the cores did not halt in time");
    end

endmodule

`default_nettype wire

// ==== test/core_vectors.txt ====
// columns: core, flags, instruction, expected acc after retire, store address
// flags: 1 random immediate, 2 acc adds that random, 4 store expected, 8 halt
0 0 01000012 00000012 00
0 4 04000010 00000012 10
0 0 01000030 00000030 00
0 0 03000010 00000042 00
0 4 04000011 00000042 11
0 3 01000000 00000000 00
0 6 04000012 00000000 12
0 0 01000005 00000005 00
0 2 03000012 00000005 00
0 2 03000011 00000047 00
0 2 00000000 00000047 00
0 0 02000010 00000012 00
0 8 ff000000 00000000 00
1 0 01000100 00000100 00
1 4 04000040 00000100 40
1 0 03000040 00000200 00
1 4 04000041 00000200 41
1 0 0200007f 00000000 00
1 0 03000041 00000200 00
1 3 01000000 00000000 00
1 2 03000040 00000100 00
1 6 04000042 00000100 42
1 2 02000042 00000100 00
1 8 ff000000 00000000 00
// end of vectors
ffffffff 0 00000000 00000000 00

// ==== build.f ====
+incdir+test
design/mc_pkg.sv
design/core_bus_if.sv
design/mini_core.sv
design/bus_arbiter.sv
design/shared_dram.sv
design/dual_core_top.sv
test/tb_clock_gen.sv
test/tb_dual_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the dual-core testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_dual_core -o sim_dual_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

./obj_dir/sim_dual_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation reported failure"
    exit "$status"
fi

exit 0
